//--- Bender.yml
package:
  name: l1d_cache

sources:
  - files:
      - l1d_pkg.sv
      - l1d_way_if.sv
      - l1d_way.sv
      - l1d_hit_merge.sv
      - l1d_ctrl.sv
      - l1d_cache.sv
  - target: test
    files:
      - l1d_cache_sva.sv
      - tb_l1d_cache.sv

//--- l1d_cache.f
l1d_pkg.sv
l1d_way_if.sv
l1d_way.sv
l1d_hit_merge.sv
l1d_ctrl.sv
l1d_cache.sv
l1d_cache_sva.sv
tb_l1d_cache.sv

//--- l1d_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_cache #(
    parameter int  NUM_WAYS    = 4,
    parameter int  NUM_SETS    = 16,
    parameter int  BLOCK_WORDS = 4,
    localparam int BLOCK_W = BLOCK_WORDS * l1d_pkg::WORD_W
) (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic               req_we_i,
    input  l1d_pkg::addr_t     req_addr_i,
    input  l1d_pkg::word_t     req_wdata_i,

    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output l1d_pkg::word_t     rsp_rdata_o,

    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output logic               mem_req_we_o,
    output l1d_pkg::addr_t     mem_req_addr_o,
    output logic [BLOCK_W-1:0] mem_req_block_o,

    input  logic               mem_rsp_valid_i,
    output logic               mem_rsp_ready_o,
    input  logic [BLOCK_W-1:0] mem_rsp_block_i
);
    import l1d_pkg::*;

    localparam int WAY_W  = $clog2(NUM_WAYS);
    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int OFF_W  = $clog2(BLOCK_WORDS);
    localparam int BYTE_W = $clog2(WORD_W / 8);
    localparam int TAG_W  = ADDR_W - IDX_W - OFF_W - BYTE_W;

    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    word_t              rd_word;
    logic [WAY_W-1:0]   victim_way;
    logic [TAG_W-1:0]   victim_tag;
    logic [BLOCK_W-1:0] victim_block;
    logic               victim_dirty;
    logic [WAY_W-1:0]   rr_ptr;

    l1d_way_if #(
        .NUM_SETS    (NUM_SETS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) way_if [NUM_WAYS] ();

    l1d_ctrl #(
        .NUM_WAYS    (NUM_WAYS),
        .NUM_SETS    (NUM_SETS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_ctrl (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_we_i        (req_we_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_rdata_o     (rsp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_block_o (mem_req_block_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .mem_rsp_block_i (mem_rsp_block_i),
        .ways_o          (way_if),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .rd_word_i       (rd_word),
        .victim_way_i    (victim_way),
        .victim_tag_i    (victim_tag),
        .victim_block_i  (victim_block),
        .victim_dirty_i  (victim_dirty),
        .rr_ptr_o        (rr_ptr)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        l1d_way #(
            .NUM_SETS    (NUM_SETS),
            .BLOCK_WORDS (BLOCK_WORDS)
        ) i_way (
            .clk_i  (clk_i),
            .rstn_i (rstn_i),
            .way_o  (way_if[g])
        );
    end

    l1d_hit_merge #(
        .NUM_WAYS    (NUM_WAYS),
        .NUM_SETS    (NUM_SETS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_merge (
        .ways_i         (way_if),
        .rr_ptr_i       (rr_ptr),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .rd_word_o      (rd_word),
        .victim_way_o   (victim_way),
        .victim_tag_o   (victim_tag),
        .victim_block_o (victim_block),
        .victim_dirty_o (victim_dirty)
    );

endmodule

`default_nettype wire

//--- l1d_cache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_cache_sva #(
    parameter int BLOCK_W = 128
) (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               req_ready_o,
    input logic               rsp_valid_o,
    input logic               rsp_ready_i,
    input l1d_pkg::word_t     rsp_rdata_o,
    input logic               mem_req_valid_o,
    input logic               mem_req_ready_i,
    input logic               mem_req_we_o,
    input l1d_pkg::addr_t     mem_req_addr_o,
    input logic [BLOCK_W-1:0] mem_req_block_o,
    input logic               mem_rsp_ready_o
);
    int unsigned fail_cnt = 0;

    // Controller leaves reset idle with no memory traffic
    reset_idle: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> req_ready_o && !rsp_valid_o && !mem_req_valid_o && !mem_rsp_ready_o)
        else begin
            $error("Controller not idle after reset");
            fail_cnt++;
        end

    rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o))
        else begin
            $error("Response dropped or changed before it was taken");
            fail_cnt++;
        end

    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_we_o)
            && $stable(mem_req_addr_o) && $stable(mem_req_block_o))
        else begin
            $error("Memory request changed before it was accepted");
            fail_cnt++;
        end

    // A pending response or memory access blocks new requests
    busy_not_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o || mem_req_valid_o || mem_rsp_ready_o |-> !req_ready_o)
        else begin
            $error("Request channel ready while the controller is busy");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- l1d_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_ctrl #(
    parameter int  NUM_WAYS    = 4,
    parameter int  NUM_SETS    = 16,
    parameter int  BLOCK_WORDS = 4,
    localparam int WAY_W   = $clog2(NUM_WAYS),
    localparam int IDX_W   = $clog2(NUM_SETS),
    localparam int OFF_W   = $clog2(BLOCK_WORDS),
    localparam int BYTE_W  = $clog2(l1d_pkg::WORD_W / 8),
    localparam int TAG_W   = l1d_pkg::ADDR_W - IDX_W - OFF_W - BYTE_W,
    localparam int BLOCK_W = BLOCK_WORDS * l1d_pkg::WORD_W
) (
    input  logic               clk_i,
    input  logic               rstn_i,

    // Client request
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic               req_we_i,
    input  l1d_pkg::addr_t     req_addr_i,
    input  l1d_pkg::word_t     req_wdata_i,

    // Client response
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output l1d_pkg::word_t     rsp_rdata_o,

    // Next level request
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output logic               mem_req_we_o,
    output l1d_pkg::addr_t     mem_req_addr_o,
    output logic [BLOCK_W-1:0] mem_req_block_o,

    // Next level refill data
    input  logic               mem_rsp_valid_i,
    output logic               mem_rsp_ready_o,
    input  logic [BLOCK_W-1:0] mem_rsp_block_i,

    l1d_way_if.ctrl            ways_o [NUM_WAYS],

    // Merged way results
    input  logic               hit_i,
    input  logic [WAY_W-1:0]   hit_way_i,
    input  l1d_pkg::word_t     rd_word_i,
    input  logic [WAY_W-1:0]   victim_way_i,
    input  logic [TAG_W-1:0]   victim_tag_i,
    input  logic [BLOCK_W-1:0] victim_block_i,
    input  logic               victim_dirty_i,
    output logic [WAY_W-1:0]   rr_ptr_o
);
    import l1d_pkg::*;

    ctrl_state_e state_r;
    ctrl_state_e state_ns;

    // Accepted request
    addr_t req_addr_r;
    word_t req_wdata_r;
    logic  req_we_r;

    word_t rsp_rdata_r;

    // Victim latched on a miss
    logic [WAY_W-1:0]   vic_way_r;
    logic [TAG_W-1:0]   vic_tag_r;
    logic [BLOCK_W-1:0] vic_block_r;

    logic [WAY_W-1:0] rr_ptr_r;

    logic [IDX_W-1:0] req_set;
    logic [TAG_W-1:0] req_tag;
    logic [OFF_W-1:0] req_off;

    logic req_fire;
    logic wr_hit;
    logic wb_done;
    logic fill_done;

    assign req_off = req_addr_r[BYTE_W +: OFF_W];
    assign req_set = req_addr_r[BYTE_W+OFF_W +: IDX_W];
    assign req_tag = req_addr_r[ADDR_W-1 -: TAG_W];

    assign req_ready_o     = (state_r == IDLE);
    assign rsp_valid_o     = (state_r == RESPOND);
    assign rsp_rdata_o     = rsp_rdata_r;
    assign mem_req_valid_o = (state_r == WB_REQ) || (state_r == FILL_REQ);
    assign mem_req_we_o    = (state_r == WB_REQ);
    assign mem_req_block_o = vic_block_r;
    assign mem_rsp_ready_o = (state_r == FILL_WAIT);
    assign rr_ptr_o        = rr_ptr_r;

    // Block aligned, victim tag for the write-back and request tag for the refill
    assign mem_req_addr_o = (state_r == WB_REQ) ?
                            {vic_tag_r, req_set, {(OFF_W+BYTE_W){1'b0}}} :
                            {req_tag, req_set, {(OFF_W+BYTE_W){1'b0}}};

    assign req_fire  = req_valid_i && req_ready_o;
    assign wr_hit    = (state_r == LOOKUP) && hit_i && req_we_r;
    assign wb_done   = (state_r == WB_REQ) && mem_req_ready_i;
    assign fill_done = mem_rsp_valid_i && mem_rsp_ready_o;

    // Every way sees the lookup, only the selected one gets an enable
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way_drv
        assign ways_o[g].set_idx    = req_set;
        assign ways_o[g].tag        = req_tag;
        assign ways_o[g].word_sel   = req_off;
        assign ways_o[g].wr_word_en = wr_hit && (hit_way_i == WAY_W'(g));
        assign ways_o[g].wr_word    = req_wdata_r;
        assign ways_o[g].fill_en    = fill_done && (vic_way_r == WAY_W'(g));
        assign ways_o[g].fill_block = mem_rsp_block_i;
        assign ways_o[g].clean_en   = wb_done && (vic_way_r == WAY_W'(g));
    end

    always_comb begin
        state_ns = state_r;
        unique case (state_r)
            IDLE: begin
                if (req_fire) state_ns = LOOKUP;
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_ns = req_we_r ? IDLE : RESPOND;
                end else if (victim_dirty_i) begin
                    state_ns = WB_REQ;
                end else begin
                    state_ns = FILL_REQ;
                end
            end
            WB_REQ: begin
                if (mem_req_ready_i) state_ns = FILL_REQ;
            end
            FILL_REQ: begin
                if (mem_req_ready_i) state_ns = FILL_WAIT;
            end
            // Look the request up again, it hits now
            FILL_WAIT: begin
                if (mem_rsp_valid_i) state_ns = LOOKUP;
            end
            RESPOND: begin
                if (rsp_ready_i) state_ns = IDLE;
            end
            default: state_ns = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r  <= IDLE;
            rr_ptr_r <= '0;
        end else begin
            state_r <= state_ns;
            if (fill_done) begin
                rr_ptr_r <= (rr_ptr_r == WAY_W'(NUM_WAYS - 1)) ? '0 : rr_ptr_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_addr_r  <= req_addr_i;
            req_wdata_r <= req_wdata_i;
            req_we_r    <= req_we_i;
        end
        if (state_r == LOOKUP) begin
            if (!hit_i) begin
                vic_way_r   <= victim_way_i;
                vic_tag_r   <= victim_tag_i;
                vic_block_r <= victim_block_i;
            end else if (!req_we_r) begin
                rsp_rdata_r <= rd_word_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- l1d_hit_merge.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_hit_merge #(
    parameter int  NUM_WAYS    = 4,
    parameter int  NUM_SETS    = 16,
    parameter int  BLOCK_WORDS = 4,
    localparam int WAY_W   = $clog2(NUM_WAYS),
    localparam int IDX_W   = $clog2(NUM_SETS),
    localparam int OFF_W   = $clog2(BLOCK_WORDS),
    localparam int BYTE_W  = $clog2(l1d_pkg::WORD_W / 8),
    localparam int TAG_W   = l1d_pkg::ADDR_W - IDX_W - OFF_W - BYTE_W,
    localparam int BLOCK_W = BLOCK_WORDS * l1d_pkg::WORD_W
) (
    l1d_way_if.merge        ways_i [NUM_WAYS],
    input  logic [WAY_W-1:0]   rr_ptr_i,
    output logic               hit_o,
    output logic [WAY_W-1:0]   hit_way_o,
    output l1d_pkg::word_t     rd_word_o,
    output logic [WAY_W-1:0]   victim_way_o,
    output logic [TAG_W-1:0]   victim_tag_o,
    output logic [BLOCK_W-1:0] victim_block_o,
    output logic               victim_dirty_o
);
    import l1d_pkg::*;

    logic [NUM_WAYS-1:0] hit_vec;
    logic [NUM_WAYS-1:0] valid_vec;
    logic [NUM_WAYS-1:0] dirty_vec;
    logic [TAG_W-1:0]    tag_arr   [NUM_WAYS];
    logic [BLOCK_W-1:0]  block_arr [NUM_WAYS];
    logic [OFF_W-1:0]    word_sel;

    // Interface arrays only take constant indices
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_unpack
        assign hit_vec[g]   = ways_i[g].hit;
        assign valid_vec[g] = ways_i[g].way_valid;
        assign dirty_vec[g] = ways_i[g].way_dirty;
        assign tag_arr[g]   = ways_i[g].way_tag;
        assign block_arr[g] = ways_i[g].way_block;
    end

    assign word_sel = ways_i[0].word_sel;

    always_comb begin
        hit_way_o    = '0;
        victim_way_o = rr_ptr_i;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) hit_way_o = WAY_W'(w);
            // Lowest invalid way wins over the round-robin pointer
            if (!valid_vec[w]) victim_way_o = WAY_W'(w);
        end
    end

    assign hit_o          = |hit_vec;
    assign rd_word_o      = block_arr[hit_way_o][word_sel*WORD_W +: WORD_W];
    assign victim_tag_o   = tag_arr[victim_way_o];
    assign victim_block_o = block_arr[victim_way_o];
    assign victim_dirty_o = valid_vec[victim_way_o] && dirty_vec[victim_way_o];

endmodule

`default_nettype wire

//--- l1d_pkg.sv
`default_nettype none

package l1d_pkg;

    // Byte address and data word widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // Controller states
    // IDLE       waits for a client request
    // LOOKUP     compares the tags of all ways for the registered request
    // WB_REQ     writes the dirty victim block to the next level
    // FILL_REQ   requests the missing block
    // FILL_WAIT  waits for the refill data
    // RESPOND    holds the read data until the client takes it
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WB_REQ    = 3'd2,
        FILL_REQ  = 3'd3,
        FILL_WAIT = 3'd4,
        RESPOND   = 3'd5
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- l1d_way.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_way #(
    parameter int NUM_SETS    = 16,
    parameter int BLOCK_WORDS = 4
) (
    input  logic    clk_i,
    input  logic    rstn_i,
    l1d_way_if.way  way_o
);
    import l1d_pkg::*;

    localparam int IDX_W   = $clog2(NUM_SETS);
    localparam int OFF_W   = $clog2(BLOCK_WORDS);
    localparam int BYTE_W  = $clog2(WORD_W / 8);
    localparam int TAG_W   = ADDR_W - IDX_W - OFF_W - BYTE_W;
    localparam int BLOCK_W = BLOCK_WORDS * WORD_W;

    logic [TAG_W-1:0]    tag_r   [NUM_SETS];
    logic [BLOCK_W-1:0]  block_r [NUM_SETS];
    logic [NUM_SETS-1:0] valid_r;
    logic [NUM_SETS-1:0] dirty_r;

    logic [IDX_W-1:0] set_idx;
    logic [OFF_W-1:0] word_sel;

    assign set_idx  = way_o.set_idx;
    assign word_sel = way_o.word_sel;

    // Asynchronous read of the addressed set
    assign way_o.way_tag   = tag_r[set_idx];
    assign way_o.way_block = block_r[set_idx];
    assign way_o.way_valid = valid_r[set_idx];
    assign way_o.way_dirty = dirty_r[set_idx];
    assign way_o.hit       = valid_r[set_idx] && (tag_r[set_idx] == way_o.tag);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_r <= '0;
            dirty_r <= '0;
        end else if (way_o.fill_en) begin
            // A fresh block is clean
            valid_r[set_idx] <= 1'b1;
            dirty_r[set_idx] <= 1'b0;
        end else if (way_o.wr_word_en) begin
            dirty_r[set_idx] <= 1'b1;
        end else if (way_o.clean_en) begin
            dirty_r[set_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (way_o.fill_en) begin
            tag_r[set_idx]   <= way_o.tag;
            block_r[set_idx] <= way_o.fill_block;
        end else if (way_o.wr_word_en) begin
            block_r[set_idx][word_sel*WORD_W +: WORD_W] <= way_o.wr_word;
        end
    end

endmodule

`default_nettype wire

//--- l1d_way_if.sv
`timescale 1ns/1ps
`default_nettype none

interface l1d_way_if #(
    parameter int NUM_SETS    = 16,
    parameter int BLOCK_WORDS = 4
);
    import l1d_pkg::*;

    localparam int IDX_W   = $clog2(NUM_SETS);
    localparam int OFF_W   = $clog2(BLOCK_WORDS);
    localparam int BYTE_W  = $clog2(WORD_W / 8);
    localparam int TAG_W   = ADDR_W - IDX_W - OFF_W - BYTE_W;
    localparam int BLOCK_W = BLOCK_WORDS * WORD_W;

    // Controller to way
    logic [IDX_W-1:0]   set_idx;
    logic [TAG_W-1:0]   tag;
    logic [OFF_W-1:0]   word_sel;
    logic               wr_word_en;
    word_t              wr_word;
    logic               fill_en;
    logic [BLOCK_W-1:0] fill_block;
    logic               clean_en;

    // Way to merge
    logic               hit;
    logic [TAG_W-1:0]   way_tag;
    logic [BLOCK_W-1:0] way_block;
    logic               way_valid;
    logic               way_dirty;

    modport ctrl (
        output set_idx, tag, word_sel, wr_word_en, wr_word, fill_en, fill_block, clean_en
    );

    modport way (
        input  set_idx, tag, word_sel, wr_word_en, wr_word, fill_en, fill_block, clean_en,
        output hit, way_tag, way_block, way_valid, way_dirty
    );

    // Word offset is needed to pick the read word out of the hitting block
    modport merge (
        input word_sel, hit, way_tag, way_block, way_valid, way_dirty
    );

endinterface

`default_nettype wire

//--- tb_l1d_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_cache;
    import l1d_pkg::*;

    localparam int NUM_WAYS    = 4;
    localparam int NUM_SETS    = 16;
    localparam int BLOCK_WORDS = 4;
    localparam int BLOCK_W     = BLOCK_WORDS * WORD_W;
    localparam int SET_LSB     = $clog2(WORD_W / 8) + $clog2(BLOCK_WORDS);
    localparam int TAG_LSB     = SET_LSB + $clog2(NUM_SETS);
    localparam int RAND_OPS    = 300;
    // Two reads, two write/read pairs, then a full set written and read back
    localparam int NUM_OPS     = 2 + 4 + 2 * (NUM_WAYS + 1) + RAND_OPS;
    localparam int MAX_CYCLES  = NUM_OPS * 40 + 200;

    logic               clk_i = 1'b0;
    logic               rstn_i;
    logic               req_valid_i;
    logic               req_ready_o;
    logic               req_we_i;
    addr_t              req_addr_i;
    word_t              req_wdata_i;
    logic               rsp_valid_o;
    logic               rsp_ready_i;
    word_t              rsp_rdata_o;
    logic               mem_req_valid_o;
    logic               mem_req_ready_i;
    logic               mem_req_we_o;
    addr_t              mem_req_addr_o;
    logic [BLOCK_W-1:0] mem_req_block_o;
    logic               mem_rsp_valid_i;
    logic               mem_rsp_ready_o;
    logic [BLOCK_W-1:0] mem_rsp_block_i;

    integer      seed = 32'hbe2b;
    word_t       mem_model [addr_t];
    word_t       shadow    [addr_t];
    int unsigned mem_rd_cnt       = 0;
    int unsigned mem_wr_cnt       = 0;
    int unsigned mem_valid_cycles = 0;
    int unsigned req_wait         = 0;
    int unsigned rsp_wait         = 0;
    logic        rsp_pend         = 1'b0;
    addr_t       rsp_addr         = '0;
    addr_t       last_rd_addr     = '0;

    l1d_cache i_dut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_we_i        (req_we_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_rdata_o     (rsp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_block_o (mem_req_block_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .mem_rsp_block_i (mem_rsp_block_i)
    );

    bind l1d_cache l1d_cache_sva #(.BLOCK_W(BLOCK_W)) i_sva (.*);

    always #50 clk_i = ~clk_i;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic addr_t make_addr(input int unsigned tag, input int unsigned set,
                                        input int unsigned off);
        return addr_t'((tag << TAG_LSB) | (set << SET_LSB) | (off << 2));
    endfunction

    // Background contents of the next level
    function automatic word_t init_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t model_word(input addr_t a);
        return mem_model.exists(a) ? mem_model[a] : init_word(a);
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    function automatic logic [BLOCK_W-1:0] refill_block(input addr_t base);
        logic [BLOCK_W-1:0] blk;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            blk[i*WORD_W +: WORD_W] = model_word(base + addr_t'(4 * i));
        end
        return blk;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first failed check");
    endtask

    // A written-back block must hold exactly what the client wrote
    task automatic store_block(input addr_t base, input logic [BLOCK_W-1:0] blk);
        addr_t a;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            a = base + addr_t'(4 * i);
            assert (blk[i*WORD_W +: WORD_W] == expected_word(a))
                else report_mismatch($sformatf("write-back of %h holds %h, expected %h",
                                     a, blk[i*WORD_W +: WORD_W], expected_word(a)));
            mem_model[a] = blk[i*WORD_W +: WORD_W];
        end
    endtask

    // Next level memory with random request and refill delays
    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (mem_req_valid_o) begin
                mem_valid_cycles++;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                mem_req_ready_i <= 1'b0;
                req_wait = rand_below(4);
                assert (mem_req_addr_o[SET_LSB-1:0] == '0)
                    else report_mismatch($sformatf("memory address %h not block aligned",
                                         mem_req_addr_o));
                if (mem_req_we_o) begin
                    mem_wr_cnt++;
                    store_block(mem_req_addr_o, mem_req_block_o);
                end else begin
                    mem_rd_cnt++;
                    last_rd_addr = mem_req_addr_o;
                    rsp_addr     = mem_req_addr_o;
                    rsp_wait     = rand_below(4);
                    rsp_pend     = 1'b1;
                end
            end else if (mem_req_valid_o) begin
                if (req_wait == 0) begin
                    mem_req_ready_i <= 1'b1;
                end else begin
                    req_wait--;
                end
            end
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                mem_rsp_valid_i <= 1'b0;
            end else if (rsp_pend && !mem_rsp_valid_i) begin
                if (rsp_wait == 0) begin
                    mem_rsp_valid_i <= 1'b1;
                    mem_rsp_block_i <= refill_block(rsp_addr);
                    rsp_pend = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        rsp_ready_i <= rstn_i && (rand_below(4) != 0);
    end

    always @(posedge clk_i) begin
        if (i_dut.i_sva.fail_cnt != 0) begin
            $display("A bound reset or handshake assertion failed");
            $display("Result: FAILED");
            $fatal(1, "Bound assertion failure");
        end
    end

    // Drives one client access and counts the edges from acceptance to completion
    task automatic access(input logic we, input addr_t addr, input word_t wdata,
                          output int unsigned lat);
        word_t exp;
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        do begin
            @(posedge clk_i);
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
        if (we) begin
            shadow[addr] = wdata;
        end
        exp = expected_word(addr);
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
        end while (we ? !req_ready_o : !rsp_valid_o);
        if (!we) begin
            while (!rsp_ready_i) begin
                @(posedge clk_i);
            end
            assert (rsp_rdata_o == exp)
                else report_mismatch($sformatf("read of %h returned %h, expected %h",
                                     addr, rsp_rdata_o, exp));
        end
    endtask

    initial begin : main
        int unsigned lat;
        int unsigned rd_before;
        int unsigned wr_before;
        int unsigned valid_before;
        addr_t       a;
        word_t       d;
        logic        we;

        rstn_i          = 1'b0;
        req_valid_i     = 1'b0;
        req_we_i        = 1'b0;
        req_addr_i      = '0;
        req_wdata_i     = '0;
        rsp_ready_i     = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_block_i = '0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Cold miss fetches the aligned block once
        a = make_addr(32'h012, 3, 1);
        rd_before = mem_rd_cnt;
        access(1'b0, a, '0, lat);
        assert (mem_rd_cnt == rd_before + 1 && last_rd_addr == make_addr(32'h012, 3, 0))
            else report_mismatch($sformatf("miss on %h fetched %0d blocks, last at %h",
                                 a, mem_rd_cnt - rd_before, last_rd_addr));
        valid_before = mem_valid_cycles;
        access(1'b0, a + 4, '0, lat);
        assert (lat == 2 && mem_valid_cycles == valid_before)
            else report_mismatch($sformatf("read hit took %0d cycles", lat));

        // Write allocate on a miss, then a write hit in the same block
        a = make_addr(32'h020, 5, 2);
        access(1'b1, a, 32'hcafe_0001, lat);
        access(1'b0, a, '0, lat);
        access(1'b1, a + 4, 32'hcafe_0002, lat);
        assert (lat == 2)
            else report_mismatch($sformatf("write to a cached block took %0d cycles", lat));
        access(1'b0, a + 4, '0, lat);

        // One tag more than the set has ways
        wr_before = mem_wr_cnt;
        for (int t = 0; t <= NUM_WAYS; t++) begin
            access(1'b1, make_addr(32'h100 + t, 9, 1), 32'h05e7_0000 + t, lat);
        end
        assert (mem_wr_cnt > wr_before)
            else report_mismatch("no write-back after overfilling a set");
        for (int t = 0; t <= NUM_WAYS; t++) begin
            access(1'b0, make_addr(32'h100 + t, 9, 1), '0, lat);
        end

        for (int i = 0; i < RAND_OPS; i++) begin
            we = (rand_below(2) == 1);
            a  = make_addr(32'h200 + rand_below(8), 10 + rand_below(3), rand_below(4));
            d  = $random(seed);
            access(we, a, d, lat);
        end

        @(posedge clk_i);
        if (i_dut.i_sva.fail_cnt == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("A bound reset or handshake assertion failed");
            $display("Result: FAILED");
            $fatal(1, "Bound assertion failure");
        end
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk_i);
        $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
